// File: hw/csrBlock.sv
module csrBlock #(
    parameter logic [csrPkg::xlen-1:0] isaId         = '0,
    parameter logic [csrPkg::xlen-1:0] vendorId      = '0,
    parameter logic [csrPkg::xlen-1:0] archId        = '0,
    parameter logic [csrPkg::xlen-1:0] impId         = '0,
    parameter logic [csrPkg::xlen-1:0] hartId        = '0,
    parameter logic [csrPkg::xlen-1:0] clockKhz      = 32'd100_000,
    parameter int                      ledCount      = 4,
    parameter logic [ledCount-1:0]     ledResetValue = 1,
    parameter int                      timerWidth    = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  csrPkg::csrAddrT         addr,
    input  csrPkg::csrOpT           modify,
    input  logic [csrPkg::xlen-1:0] wdata,
    output logic [csrPkg::xlen-1:0] rdata,
    output logic                    valid,
    input  logic                    retired,
    output logic [ledCount-1:0]     outpins,
    output logic                    irq
);
    import csrPkg::*;

    logic [xlen-1:0] cycleLo;
    logic [xlen-1:0] cycleHi;
    logic [xlen-1:0] instretLo;
    logic [xlen-1:0] instretHi;
    logic [xlen-1:0] ledState;
    csrOpT           ledOp;
    logic            timerLoad;
    logic            timerStop;

    // Decoder and read mux
    csrControl #(
        .isaId    (isaId),
        .vendorId (vendorId),
        .archId   (archId),
        .impId    (impId),
        .hartId   (hartId),
        .clockKhz (clockKhz),
        .ledCount (ledCount)
    ) control (
        .clk       (clk),
        .rstn      (rstn),
        .addr      (addr),
        .modify    (modify),
        .valid     (valid),
        .rdata     (rdata),
        .cycleLo   (cycleLo),
        .cycleHi   (cycleHi),
        .instretLo (instretLo),
        .instretHi (instretHi),
        .ledState  (ledState),
        .ledOp     (ledOp),
        .timerLoad (timerLoad),
        .timerStop (timerStop)
    );

    csrCounters counters (
        .clk       (clk),
        .rstn      (rstn),
        .retired   (retired),
        .cycleLo   (cycleLo),
        .cycleHi   (cycleHi),
        .instretLo (instretLo),
        .instretHi (instretHi)
    );

    csrLedPins #(
        .ledCount      (ledCount),
        .ledResetValue (ledResetValue)
    ) ledPins (
        .clk      (clk),
        .rstn     (rstn),
        .ledOp    (ledOp),
        .wdata    (wdata),
        .outpins  (outpins),
        .ledState (ledState)
    );

    csrTimer #(
        .timerWidth (timerWidth)
    ) timer (
        .clk       (clk),
        .rstn      (rstn),
        .timerLoad (timerLoad),
        .timerStop (timerStop),
        .wdata     (wdata),
        .irq       (irq)
    );

endmodule

// File: hw/csrControl.sv
module csrControl #(
    parameter logic [csrPkg::xlen-1:0] isaId    = '0,
    parameter logic [csrPkg::xlen-1:0] vendorId = '0,
    parameter logic [csrPkg::xlen-1:0] archId   = '0,
    parameter logic [csrPkg::xlen-1:0] impId    = '0,
    parameter logic [csrPkg::xlen-1:0] hartId   = '0,
    parameter logic [csrPkg::xlen-1:0] clockKhz = 32'd100_000,
    parameter int                      ledCount = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  csrPkg::csrAddrT         addr,
    input  csrPkg::csrOpT           modify,
    output logic                    valid,
    output logic [csrPkg::xlen-1:0] rdata,
    input  logic [csrPkg::xlen-1:0] cycleLo,
    input  logic [csrPkg::xlen-1:0] cycleHi,
    input  logic [csrPkg::xlen-1:0] instretLo,
    input  logic [csrPkg::xlen-1:0] instretHi,
    input  logic [csrPkg::xlen-1:0] ledState,
    output csrPkg::csrOpT           ledOp,
    output logic                    timerLoad,
    output logic                    timerStop
);
    import csrPkg::*;

    csrSelT            selNext;
    csrSelT            selReg;
    logic [xlen-1:0]   readNext;

    // Decode stage
    always_comb begin
        case (addr)
            addrMisa:                          selNext = selIsa;
            addrVendor:                        selNext = selVendor;
            addrArch:                          selNext = selArch;
            addrImp:                           selNext = selImp;
            addrHart:                          selNext = selHart;
            addrKhz:                           selNext = selKhz;
            addrCycle, addrMcycle, addrTime:   selNext = selCycleLo;
            addrCycleH, addrMcycleH, addrTimeH: selNext = selCycleHi;
            addrInstret, addrMinstret:         selNext = selInstretLo;
            addrInstretH, addrMinstretH:       selNext = selInstretHi;
            addrLeds:                          selNext = selLeds;
            addrTimer:                         selNext = selTimer;
            default:                           selNext = selNone;
        endcase
    end

    assign valid = (selNext != selNone);

    // Execute stage strobes
    assign ledOp     = (selReg == selLeds) ? modify : opNone;
    assign timerLoad = (selReg == selTimer) && (modify == opWrite);
    assign timerStop = (selReg == selTimer) && (modify == opClear);

    always_comb begin
        case (selReg)
            selIsa:       readNext = isaId;
            selVendor:    readNext = vendorId;
            selArch:      readNext = archId;
            selImp:       readNext = impId;
            selHart:      readNext = hartId;
            selKhz:       readNext = clockKhz;
            selCycleLo:   readNext = cycleLo;
            selCycleHi:   readNext = cycleHi;
            selInstretLo: readNext = instretLo;
            selInstretHi: readNext = instretHi;
            selLeds:      readNext = xlen'(ledState[ledCount-1:0]);
            default:      readNext = '0; // Timer reads zero too
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            selReg <= selNone;
            rdata  <= '0;
        end else begin
            selReg <= selNext;
            rdata  <= readNext; // Old value when written in the same access
        end
    end

endmodule

// File: hw/csrCounters.sv
module csrCounters (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    retired,
    output logic [csrPkg::xlen-1:0] cycleLo,
    output logic [csrPkg::xlen-1:0] cycleHi,
    output logic [csrPkg::xlen-1:0] instretLo,
    output logic [csrPkg::xlen-1:0] instretHi
);
    import csrPkg::*;

    // Low words keep their carry in the top bit for one cycle
    logic [xlen:0]   cycleLoReg;
    logic [xlen-1:0] cycleHiReg;
    logic [xlen:0]   instretLoReg;
    logic [xlen-1:0] instretHiReg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycleLoReg <= '0;
            cycleHiReg <= '0;
        end else begin
            cycleLoReg <= {1'b0, cycleLoReg[xlen-1:0]} + (xlen + 1)'(1);
            cycleHiReg <= cycleHiReg + xlen'(cycleLoReg[xlen]); // Carry from last edge
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instretLoReg <= '0;
            instretHiReg <= '0;
        end else begin
            instretLoReg <= {1'b0, instretLoReg[xlen-1:0]} + (xlen + 1)'(retired);
            instretHiReg <= instretHiReg + xlen'(instretLoReg[xlen]);
        end
    end

    assign cycleLo   = cycleLoReg[xlen-1:0];
    assign cycleHi   = cycleHiReg;
    assign instretLo = instretLoReg[xlen-1:0];
    assign instretHi = instretHiReg;

endmodule

// File: hw/csrLedPins.sv
module csrLedPins #(
    parameter int                  ledCount      = 4,
    parameter logic [ledCount-1:0] ledResetValue = 1
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  csrPkg::csrOpT           ledOp,
    input  logic [csrPkg::xlen-1:0] wdata,
    output logic [ledCount-1:0]     outpins,
    output logic [csrPkg::xlen-1:0] ledState
);
    import csrPkg::*;

    logic [ledCount-1:0] ledReg;
    logic [ledCount-1:0] ledBits;

    assign ledBits = wdata[ledCount-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ledReg <= ledResetValue;
        end else begin
            case (ledOp)
                opWrite: ledReg <= ledBits;
                opSet:   ledReg <= ledReg | ledBits;
                opClear: ledReg <= ledReg & ~ledBits;
                default: ;                  // No change
            endcase
        end
    end

    assign outpins  = ledReg;
    assign ledState = xlen'(ledReg);        // Zero-extended for readback

endmodule

// File: hw/csrPkg.sv
package csrPkg;

    localparam int xlen = 32;

    typedef logic [11:0] csrAddrT;

    // Machine ID registers
    localparam csrAddrT addrMisa     = 12'h301;
    localparam csrAddrT addrVendor   = 12'hF11;
    localparam csrAddrT addrArch     = 12'hF12;
    localparam csrAddrT addrImp      = 12'hF13;
    localparam csrAddrT addrHart     = 12'hF14;
    localparam csrAddrT addrKhz      = 12'hFC0; // Custom clock frequency in kHz

    // Custom read/write registers
    localparam csrAddrT addrLeds     = 12'hBC1;
    localparam csrAddrT addrTimer    = 12'hBC2;

    // Counters and their aliases
    localparam csrAddrT addrCycle    = 12'hC00;
    localparam csrAddrT addrMcycle   = 12'hB00;
    localparam csrAddrT addrTime     = 12'hC01; // Time shares the cycle counter
    localparam csrAddrT addrCycleH   = 12'hC80;
    localparam csrAddrT addrMcycleH  = 12'hB80;
    localparam csrAddrT addrTimeH    = 12'hC81;
    localparam csrAddrT addrInstret  = 12'hC02;
    localparam csrAddrT addrMinstret = 12'hB02;
    localparam csrAddrT addrInstretH = 12'hC82;
    localparam csrAddrT addrMinstretH = 12'hB82;

    typedef enum logic [2:0] {
        opNone  = 3'd0,
        opWrite = 3'd1,
        opSet   = 3'd2,
        opClear = 3'd3
    } csrOpT;

    // Register selected for the execute stage
    typedef enum logic [3:0] {
        selNone, selIsa, selVendor, selArch, selImp, selHart, selKhz,
        selCycleLo, selCycleHi, selInstretLo, selInstretHi, selLeds, selTimer
    } csrSelT;

endpackage

// File: hw/csrTimer.sv
module csrTimer #(
    parameter int timerWidth = 32
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    timerLoad,
    input  logic                    timerStop,
    input  logic [csrPkg::xlen-1:0] wdata,
    output logic                    irq
);

    logic [timerWidth-1:0] count;
    logic                  timerOn;
    logic                  irqReg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count   <= '0;
            timerOn <= 1'b0;
            irqReg  <= 1'b0;
        end else begin
            if (timerLoad) begin
                count   <= wdata[timerWidth-1:0];
                timerOn <= 1'b1;
            end else if (count != '0) begin
                count <= count - 1'b1;
            end

            if (timerStop) begin
                timerOn <= 1'b0;
            end

            // Request follows the on flag one edge late
            irqReg <= (count == '0) && timerOn;
        end
    end

    assign irq = irqReg;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the CSR block testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module csrBlockTb -f src.f -o csrBlockSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csrBlockSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$log"; then
    exit 0
fi
exit 1

// File: src.f
hw/csrPkg.sv
hw/csrControl.sv
hw/csrCounters.sv
hw/csrLedPins.sv
hw/csrTimer.sv
hw/csrBlock.sv
verif/csrBlockTb.sv

// File: verif/csrBlockTb.sv
module csrBlockTb;
    timeunit 1ns;
    timeprecision 100ps;

    import csrPkg::*;

    localparam int clkPeriod = 100;
    localparam int maxCycles = 2000;          // About four times the full sequence
    localparam csrAddrT idleAddr = 12'h000;   // Decodes to no CSR

    localparam logic [xlen-1:0] isaVal    = 32'h4000_1104; // RV32IMC
    localparam logic [xlen-1:0] vendorVal = 32'h0000_0A5C;
    localparam logic [xlen-1:0] archVal   = 32'h0000_0017;
    localparam logic [xlen-1:0] impVal    = 32'h0001_0203;
    localparam logic [xlen-1:0] hartVal   = 32'h0000_0003;
    localparam logic [xlen-1:0] khzVal    = 32'd50_000;

    logic            clk;
    logic            rstn;
    csrAddrT         addr;
    csrOpT           modify;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;
    logic            valid;
    logic            retired;
    logic [3:0]      outpins;
    logic            irq;

    int         errorCount;
    int         checkCount;
    logic [3:0] ledModel;

    // Every address and alias the block decodes
    csrAddrT listed [18] = '{
        addrMisa, addrVendor, addrArch, addrImp, addrHart, addrKhz, addrLeds, addrTimer,
        addrCycle, addrMcycle, addrTime, addrCycleH, addrMcycleH, addrTimeH,
        addrInstret, addrMinstret, addrInstretH, addrMinstretH
    };

    csrBlock #(
        .isaId         (isaVal),
        .vendorId      (vendorVal),
        .archId        (archVal),
        .impId         (impVal),
        .hartId        (hartVal),
        .clockKhz      (khzVal),
        .ledCount      (4),
        .ledResetValue (4'b0001),
        .timerWidth    (32)
    ) dut (
        .clk     (clk),
        .rstn    (rstn),
        .addr    (addr),
        .modify  (modify),
        .wdata   (wdata),
        .rdata   (rdata),
        .valid   (valid),
        .retired (retired),
        .outpins (outpins),
        .irq     (irq)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic expectEqual(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[ERROR] %s expected 0x%08h, got 0x%08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // Address in cycle n and opcode in n+1 with read data sampled in n+2
    task automatic doAccess(input csrAddrT a, input csrOpT op, input logic [xlen-1:0] d,
                            output logic [xlen-1:0] rd);
        @(posedge clk);
        addr <= a;
        @(posedge clk);
        addr   <= idleAddr;
        modify <= op;
        wdata  <= d;
        @(posedge clk);
        modify <= opNone;
        @(negedge clk);
        rd = rdata;
    endtask

    function automatic bit knownAddr(input csrAddrT a);
        foreach (listed[i]) begin
            if (listed[i] == a) return 1'b1;
        end
        return 1'b0;
    endfunction

    initial begin
        logic [xlen-1:0] rd;
        logic [xlen-1:0] first;
        logic [xlen-1:0] second;
        logic [xlen-1:0] loadVal;
        logic [2:0]      opBits;
        logic            pulse;
        csrAddrT         randAddr;
        int              gap;
        int              pulses;
        int              edges;

        void'($urandom(37));
        clk = 1'b0;
        rstn = 1'b0;
        addr = idleAddr;
        modify = opNone;
        wdata = '0;
        retired = 1'b0;
        errorCount = 0;
        checkCount = 0;
        ledModel = 4'b0001;

        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        expectEqual("irq", 0, 32'(irq));
        expectEqual("rdata", 0, rdata);
        expectEqual("outpins", 32'(ledModel), 32'(outpins));

        // Valid must follow addr within the same cycle
        foreach (listed[i]) begin
            @(posedge clk);
            addr <= listed[i];
            @(negedge clk);
            expectEqual("valid", 1, 32'(valid));
        end
        for (int i = 0; i < 20; i++) begin
            do begin
                randAddr = csrAddrT'($urandom_range(4095, 0));
            end while (knownAddr(randAddr));
            @(posedge clk);
            addr <= randAddr;
            @(negedge clk);
            expectEqual("valid", 0, 32'(valid));
        end

        doAccess(addrMisa, opNone, '0, rd);
        expectEqual("rdata", isaVal, rd);
        doAccess(addrVendor, opNone, '0, rd);
        expectEqual("rdata", vendorVal, rd);
        doAccess(addrArch, opNone, '0, rd);
        expectEqual("rdata", archVal, rd);
        doAccess(addrImp, opNone, '0, rd);
        expectEqual("rdata", impVal, rd);
        doAccess(addrHart, opNone, '0, rd);
        expectEqual("rdata", hartVal, rd);
        doAccess(addrKhz, opNone, '0, rd);
        expectEqual("rdata", khzVal, rd);
        doAccess(12'h123, opNone, '0, rd); // Unknown address
        expectEqual("rdata", 0, rd);

        // Codes above opClear must leave the LEDs alone
        for (int i = 0; i < 30; i++) begin
            opBits = 3'($urandom_range(7, 0));
            loadVal = $urandom();
            doAccess(addrLeds, csrOpT'(opBits), loadVal, rd);
            expectEqual("rdata", 32'(ledModel), rd); // Old value in the same access
            case (opBits)
                3'd1: ledModel = loadVal[3:0];
                3'd2: ledModel = ledModel | loadVal[3:0];
                3'd3: ledModel = ledModel & ~loadVal[3:0];
                default: ;
            endcase
            expectEqual("outpins", 32'(ledModel), 32'(outpins));
        end
        doAccess(addrLeds, opNone, '0, rd);
        expectEqual("rdata", 32'(ledModel), rd);

        // Back-to-back accesses start three cycles apart
        for (int i = 0; i < 2; i++) begin
            gap = $urandom_range(20, 0);
            doAccess(addrCycle, opNone, '0, first);
            repeat (gap) @(posedge clk);
            doAccess(addrCycle, opNone, '0, second);
            expectEqual("cycleLo delta", 32'(gap + 3), second - first);
        end

        doAccess(addrInstret, opNone, '0, first);
        pulses = 0;
        for (int i = 0; i < 40; i++) begin
            pulse = 1'($urandom_range(1, 0));
            @(posedge clk);
            retired <= pulse;
            pulses += int'(pulse);
        end
        @(posedge clk);
        retired <= 1'b0;
        doAccess(addrInstret, opNone, '0, second);
        expectEqual("instretLo delta", 32'(pulses), second - first);

        doAccess(addrCycleH, opNone, '0, rd);
        expectEqual("rdata", 0, rd);
        doAccess(addrMcycleH, opNone, '0, rd);
        expectEqual("rdata", 0, rd);
        doAccess(addrInstretH, opNone, '0, rd);
        expectEqual("rdata", 0, rd);
        doAccess(addrMinstretH, opNone, '0, rd);
        expectEqual("rdata", 0, rd);

        // Timer load and stop with irq expected N+1 edges after the load
        for (int i = 0; i < 3; i++) begin
            loadVal = $urandom_range(40, 2);
            doAccess(addrTimer, opWrite, loadVal, rd);
            expectEqual("rdata", 0, rd);
            edges = 0;
            while (!irq && edges < 100) begin
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            if (!irq) begin
                errorCount++;
                $display("irq never rose within 100 cycles of a timer load of %0d", loadVal);
            end else begin
                expectEqual("irq delay", loadVal + 1, 32'(edges));
            end
            repeat (3) @(posedge clk);
            @(negedge clk);
            expectEqual("irq", 1, 32'(irq)); // Held while the timer is on
            doAccess(addrTimer, opClear, '0, rd);
            expectEqual("irq", 1, 32'(irq));
            @(posedge clk);
            @(negedge clk);
            expectEqual("irq", 0, 32'(irq));
        end

        @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(maxCycles * clkPeriod);
        $display("Timeout after %0d cycles with the tests unfinished, %0d errors so far",
                 maxCycles, errorCount);
        $display("Verification failed");
        $finish;
    end

endmodule
